// File: hdl/isq_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module isq_dispatch import isq_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   dispatch_valid_i,
   input  isq_uop_t              dispatch_uop_i,
   input  wire  [ISQ_DEPTH-1:0]  entry_busy_i,
   output logic                  dispatch_ready_o,
   output logic [ISQ_DEPTH-1:0]  write_en_o,
   output isq_uop_t              write_uop_o
);

   logic [IDX_W-1:0] free_idx;
   logic             free_found;
   logic             accept;
   logic [ISQ_DEPTH-1:0] busy_q;
   logic [CNT_W-1:0] fall_cnt;
   logic [CNT_W-1:0] occ_q;

   ////////////////////////////////////////
   // lowest free entry
   ////////////////////////////////////////
   always_comb
   begin
      free_idx   = '0;
      free_found = 1'b0;
      // scan downwards so the lowest index wins
      for (int i = ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (!entry_busy_i[i])
         begin
            free_idx   = IDX_W'(i);
            free_found = 1'b1;
         end
      end
   end

   assign dispatch_ready_o = free_found;
   assign accept           = dispatch_valid_i & free_found;
   assign write_en_o       = accept ? (ISQ_DEPTH'(1) << free_idx) : '0;
   assign write_uop_o      = dispatch_uop_i;

   ////////////////////////////////////////
   // occupancy tracking
   ////////////////////////////////////////
   // frees are seen as falling busy bits, one cycle late
   always_comb
   begin
      fall_cnt = '0;
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         fall_cnt = fall_cnt + CNT_W'(busy_q[i] & ~entry_busy_i[i]);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy_q <= '0;
         occ_q  <= '0;
      end
      else
      begin
         busy_q <= entry_busy_i;
         occ_q  <= occ_q + CNT_W'(accept) - fall_cnt;
      end
   end

   // a slot freed at an edge is never refilled at that same edge
   a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n)
      occ_q <= CNT_W'(ISQ_DEPTH));

   a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(write_en_o));

endmodule

`default_nettype wire

// File: hdl/isq_entry.sv
`timescale 1ns/10ps
`default_nettype none

module isq_entry import isq_pkg::*;
(
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          write_en_i,
   input  isq_uop_t                     write_uop_i,
   input  isq_wakeup_t [WAKE_PORTS-1:0] wakeup_i,
   input  wire                          release_i,
   output logic                         busy_o,
   output logic                         ready_o,
   output isq_issue_t                   issue_uop_o
);

   logic     valid_q;
   isq_uop_t uop_q;
   isq_uop_t uop_d;

   ////////////////////////////////////////
   // tag compare against all broadcasts
   ////////////////////////////////////////
   function automatic logic tag_hit(input logic [TAG_W-1:0] tag,
                                    input isq_wakeup_t [WAKE_PORTS-1:0] wk);
      logic hit;
      hit = 1'b0;
      for (int p = 0; p < WAKE_PORTS; p++)
      begin
         if (wk[p].valid && (wk[p].tag == tag))
         begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // next line contents, wakeup applies on the write cycle too
   always_comb
   begin
      uop_d = uop_q;
      if (write_en_i)
      begin
         uop_d = write_uop_i;
      end
      uop_d.src1_rdy = uop_d.src1_rdy | tag_hit(uop_d.src1_tag, wakeup_i);
      uop_d.src2_rdy = uop_d.src2_rdy | tag_hit(uop_d.src2_tag, wakeup_i);
   end

   ////////////////////////////////////////
   // line storage
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (write_en_i)
      begin
         valid_q <= 1'b1;
      end
      else if (release_i)
      begin
         valid_q <= 1'b0;
      end
   end

   // payload only moves while occupied or being filled
   always_ff @(posedge clk)
   begin
      if (write_en_i || valid_q)
      begin
         uop_q <= uop_d;
      end
   end

   assign busy_o  = valid_q;
   assign ready_o = valid_q & uop_q.src1_rdy & uop_q.src2_rdy;

   assign issue_uop_o.opcode  = uop_q.opcode;
   assign issue_uop_o.dst_tag = uop_q.dst_tag;

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   // dispatch must only target free lines
   a_wr_free: assert property (@(posedge clk) disable iff (!rst_n)
      write_en_i |-> !valid_q);

   // select must only release a line it saw as ready
   a_rel_ready: assert property (@(posedge clk) disable iff (!rst_n)
      release_i |-> (valid_q && ready_o));

endmodule

`default_nettype wire

// File: hdl/isq_pkg.sv
`default_nettype none

////////////////////////////////////////
// issue queue shared definitions
////////////////////////////////////////
package isq_pkg;

   // queue geometry
   localparam int ISQ_DEPTH  = 8;
   localparam int IDX_W      = $clog2(ISQ_DEPTH);
   localparam int CNT_W      = $clog2(ISQ_DEPTH + 1);

   // physical tags and broadcast ports
   localparam int TAG_W      = 6;
   localparam int OPC_W      = 4;
   localparam int WAKE_PORTS = 2;

   ////////////////////////////////////////
   // micro-op as it arrives from dispatch
   ////////////////////////////////////////
   typedef struct packed
   {
      logic [OPC_W-1:0] opcode;
      logic [TAG_W-1:0] dst_tag;
      logic [TAG_W-1:0] src1_tag;
      logic             src1_rdy;
      logic [TAG_W-1:0] src2_tag;
      logic             src2_rdy;
   } isq_uop_t;

   // one result-tag broadcast
   typedef struct packed
   {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } isq_wakeup_t;

   // what leaves on the issue port
   typedef struct packed
   {
      logic [OPC_W-1:0] opcode;
      logic [TAG_W-1:0] dst_tag;
   } isq_issue_t;

endpackage

`default_nettype wire

// File: hdl/isq_select.sv
`timescale 1ns/10ps
`default_nettype none

module isq_select import isq_pkg::*;
(
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire  [ISQ_DEPTH-1:0]          entry_ready_i,
   input  isq_issue_t [ISQ_DEPTH-1:0]    entry_uop_i,
   input  wire                           issue_ready_i,
   output logic                          issue_valid_o,
   output isq_issue_t                    issue_uop_o,
   output logic [ISQ_DEPTH-1:0]          release_o
);

   logic [IDX_W-1:0] pick_idx;
   logic             pick_found;
   logic [IDX_W-1:0] sel_idx;
   logic             lock_q;
   logic [IDX_W-1:0] lock_idx_q;
   logic             fire;

   ////////////////////////////////////////
   // priority pick, lowest index first
   ////////////////////////////////////////
   always_comb
   begin
      pick_idx   = '0;
      pick_found = 1'b0;
      for (int i = ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (entry_ready_i[i])
         begin
            pick_idx   = IDX_W'(i);
            pick_found = 1'b1;
         end
      end
   end

   // locked pick overrides a fresh one
   assign sel_idx       = lock_q ? lock_idx_q : pick_idx;
   assign issue_valid_o = lock_q | pick_found;
   assign issue_uop_o   = entry_uop_i[sel_idx];
   assign fire          = issue_valid_o & issue_ready_i;
   assign release_o     = fire ? (ISQ_DEPTH'(1) << sel_idx) : '0;

   ////////////////////////////////////////
   // hold under back-pressure
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lock_q     <= 1'b0;
         lock_idx_q <= '0;
      end
      else
      begin
         lock_q     <= issue_valid_o & ~issue_ready_i;
         lock_idx_q <= sel_idx;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   // payload and valid stay put until taken
   a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (issue_valid_o && !issue_ready_i) |=> (issue_valid_o && $stable(issue_uop_o)));

   // the held line must not lose readiness while waiting
   a_lock_ready: assert property (@(posedge clk) disable iff (!rst_n)
      lock_q |-> entry_ready_i[lock_idx_q]);

endmodule

`default_nettype wire

// File: hdl/isq_top.sv
`timescale 1ns/10ps
`default_nettype none

module isq_top import isq_pkg::*;
(
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          dispatch_valid_i,
   input  isq_uop_t                     dispatch_uop_i,
   output logic                         dispatch_ready_o,
   input  isq_wakeup_t [WAKE_PORTS-1:0] wakeup_i,
   output logic                         issue_valid_o,
   output isq_issue_t                   issue_uop_o,
   input  wire                          issue_ready_i
);

   logic [ISQ_DEPTH-1:0]       entry_busy;
   logic [ISQ_DEPTH-1:0]       entry_ready;
   logic [ISQ_DEPTH-1:0]       write_en;
   logic [ISQ_DEPTH-1:0]       release_vec;
   isq_uop_t                   write_uop;
   isq_issue_t [ISQ_DEPTH-1:0] entry_uop;

   ////////////////////////////////////////
   // dispatch stage
   ////////////////////////////////////////
   isq_dispatch u_dispatch
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .dispatch_valid_i (dispatch_valid_i),
      .dispatch_uop_i   (dispatch_uop_i),
      .entry_busy_i     (entry_busy),
      .dispatch_ready_o (dispatch_ready_o),
      .write_en_o       (write_en),
      .write_uop_o      (write_uop)
   );

   ////////////////////////////////////////
   // row of queue lines
   ////////////////////////////////////////
   for (genvar g = 0; g < ISQ_DEPTH; g++)
   begin : g_entry
      isq_entry u_entry
      (
         .clk         (clk),
         .rst_n       (rst_n),
         .write_en_i  (write_en[g]),
         .write_uop_i (write_uop),
         .wakeup_i    (wakeup_i),
         .release_i   (release_vec[g]),
         .busy_o      (entry_busy[g]),
         .ready_o     (entry_ready[g]),
         .issue_uop_o (entry_uop[g])
      );
   end

   ////////////////////////////////////////
   // select and issue
   ////////////////////////////////////////
   isq_select u_select
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .entry_ready_i (entry_ready),
      .entry_uop_i   (entry_uop),
      .issue_ready_i (issue_ready_i),
      .issue_valid_o (issue_valid_o),
      .issue_uop_o   (issue_uop_o),
      .release_o     (release_vec)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue queue testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
   -f src.f \
   --top-module isq_tb \
   -o Visq_tb

./obj_dir/Visq_tb 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "result: FAIL (see $LOG)"
   exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
   echo "result: no pass message in $LOG"
   exit 1
fi

echo "result: PASS"

// File: src.f
hdl/isq_pkg.sv
hdl/isq_dispatch.sv
hdl/isq_entry.sv
hdl/isq_select.sv
hdl/isq_top.sv
tb/isq_tb.sv

// File: tb/isq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module isq_tb import isq_pkg::*;
();

   localparam int unsigned SEED       = 32'h9454_38aa;
   localparam int          NUM_UOPS   = 400;
   localparam int          MAX_CYCLES = 20000;

   logic                          clk;
   logic                          rst_n;
   logic                          dispatch_valid;
   isq_uop_t                      dispatch_uop;
   logic                          dispatch_ready;
   isq_wakeup_t [WAKE_PORTS-1:0]  wakeup;
   logic                          issue_valid;
   isq_issue_t                    issue_uop;
   logic                          issue_ready;

   // reference model state
   isq_uop_t    model_q[$];
   bit          bcast_seen [2**TAG_W];
   logic        pend_valid;
   isq_uop_t    pend_uop;
   logic        held_prev;
   isq_issue_t  held_uop;
   int          generated;
   int          issued;
   int          cycles;
   int          woke_at_write;
   int          woke_later;
   int unsigned seed_val;

   isq_top u_isq_top
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .dispatch_valid_i (dispatch_valid),
      .dispatch_uop_i   (dispatch_uop),
      .dispatch_ready_o (dispatch_ready),
      .wakeup_i         (wakeup),
      .issue_valid_o    (issue_valid),
      .issue_uop_o      (issue_uop),
      .issue_ready_i    (issue_ready)
   );

   always #20 clk = ~clk;

   ////////////////////////////////////////
   // reporting
   ////////////////////////////////////////
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("** Error at %0d ns: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   ////////////////////////////////////////
   // model helpers
   ////////////////////////////////////////
   function automatic bit wake_hit(input logic [TAG_W-1:0] tag);
      bit hit;
      hit = 1'b0;
      for (int p = 0; p < WAKE_PORTS; p++)
      begin
         if (wakeup[p].valid && wakeup[p].tag == tag)
         begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   function automatic bit any_ready_in_model();
      bit found;
      found = 1'b0;
      foreach (model_q[i])
      begin
         if (model_q[i].src1_rdy && model_q[i].src2_rdy)
         begin
            found = 1'b1;
         end
      end
      return found;
   endfunction

   function automatic int find_record(input logic [TAG_W-1:0] dst);
      int idx;
      idx = -1;
      foreach (model_q[i])
      begin
         if (idx < 0 && model_q[i].dst_tag == dst)
         begin
            idx = i;
         end
      end
      return idx;
   endfunction

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   // dst tags rotate, at most nine are in flight
   task automatic make_uop(output isq_uop_t u);
      u.opcode   = OPC_W'($urandom);
      u.dst_tag  = TAG_W'(generated);
      u.src1_tag = TAG_W'($urandom);
      u.src2_tag = TAG_W'($urandom);
      u.src1_rdy = (bcast_seen[u.src1_tag] && ($urandom % 2 == 0)) || ($urandom % 8 == 0);
      u.src2_rdy = (bcast_seen[u.src2_tag] && ($urandom % 2 == 0)) || ($urandom % 8 == 0);
   endtask

   // bias broadcasts towards tags that someone waits on
   function automatic logic [TAG_W-1:0] pick_wake_tag();
      int unsigned r;
      int          k;
      logic [TAG_W-1:0] tag;
      r   = $urandom % 4;
      tag = TAG_W'($urandom);
      if (r == 0 && pend_valid)
      begin
         tag = ($urandom % 2 == 0) ? pend_uop.src1_tag : pend_uop.src2_tag;
      end
      else if (r != 3 && model_q.size() > 0)
      begin
         k   = int'($urandom % model_q.size());
         tag = ($urandom % 2 == 0) ? model_q[k].src1_tag : model_q[k].src2_tag;
      end
      return tag;
   endfunction

   task automatic drive_wakeups();
      for (int p = 0; p < WAKE_PORTS; p++)
      begin
         wakeup[p].valid = ($urandom % 2 == 0);
         wakeup[p].tag   = pick_wake_tag();
      end
   endtask

   ////////////////////////////////////////
   // model update for the coming edge
   ////////////////////////////////////////
   task automatic update_model();
      int       idx;
      isq_uop_t rec;
      if (issue_valid && issue_ready)
      begin
         idx = find_record(issue_uop.dst_tag);
         if (idx < 0)
         begin
            abort_run("issued micro-op matches no waiting record, or was issued twice");
         end
         else
         begin
            check_value(32'(issue_uop.opcode), 32'(model_q[idx].opcode), "issued opcode");
            check_value(32'(model_q[idx].src1_rdy), 32'd1, "source one ready at issue");
            check_value(32'(model_q[idx].src2_rdy), 32'd1, "source two ready at issue");
            model_q.delete(idx);
            issued++;
         end
      end
      // wakeups on waiting records
      foreach (model_q[i])
      begin
         rec = model_q[i];
         if ((!rec.src1_rdy && wake_hit(rec.src1_tag)) ||
             (!rec.src2_rdy && wake_hit(rec.src2_tag)))
         begin
            woke_later++;
         end
         rec.src1_rdy = rec.src1_rdy | wake_hit(rec.src1_tag);
         rec.src2_rdy = rec.src2_rdy | wake_hit(rec.src2_tag);
         model_q[i]   = rec;
      end
      // write, with same-cycle wakeup
      if (dispatch_valid && dispatch_ready)
      begin
         rec = dispatch_uop;
         if ((!rec.src1_rdy && wake_hit(rec.src1_tag)) ||
             (!rec.src2_rdy && wake_hit(rec.src2_tag)))
         begin
            woke_at_write++;
         end
         rec.src1_rdy = rec.src1_rdy | wake_hit(rec.src1_tag);
         rec.src2_rdy = rec.src2_rdy | wake_hit(rec.src2_tag);
         model_q.push_back(rec);
         bcast_seen[rec.dst_tag] = 1'b0;
         pend_valid = 1'b0;
      end
      for (int p = 0; p < WAKE_PORTS; p++)
      begin
         if (wakeup[p].valid)
         begin
            bcast_seen[wakeup[p].tag] = 1'b1;
         end
      end
      held_prev = issue_valid && !issue_ready;
      held_uop  = issue_uop;
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial
   begin
      clk            = 1'b0;
      rst_n          = 1'b0;
      dispatch_valid = 1'b0;
      dispatch_uop   = '0;
      wakeup         = '0;
      issue_ready    = 1'b0;
      pend_valid     = 1'b0;
      pend_uop       = '0;
      held_prev      = 1'b0;
      held_uop       = '0;
      generated      = 0;
      issued         = 0;
      cycles         = 0;
      woke_at_write  = 0;
      woke_later     = 0;
      seed_val       = $urandom(SEED);

      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value(32'(dispatch_ready), 32'd1, "dispatch ready after reset");
      check_value(32'(issue_valid), 32'd0, "issue valid after reset");

      while (issued < NUM_UOPS)
      begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > MAX_CYCLES)
         begin
            abort_run("timeout, not all micro-ops were issued in time");
         end
         else
         begin
            // outputs after the edge against the model
            check_value(32'(dispatch_ready), 32'(model_q.size() < ISQ_DEPTH),
                        "dispatch ready vs model occupancy");
            check_value(32'(issue_valid), 32'(any_ready_in_model()),
                        "issue valid vs ready records");
            if (held_prev)
            begin
               check_value(32'(issue_valid), 32'd1, "issue valid held");
               check_value(32'(issue_uop), 32'(held_uop), "issue payload held");
            end
            if (!pend_valid && generated < NUM_UOPS && ($urandom % 4 != 0))
            begin
               make_uop(pend_uop);
               pend_valid = 1'b1;
               generated++;
            end
            dispatch_valid = pend_valid;
            dispatch_uop   = pend_uop;
            issue_ready    = ($urandom % 3 != 0);
            drive_wakeups();
            update_model();
         end
      end

      @(posedge clk);
      #2;
      // queue drained, every line must be free again
      check_value(32'(dispatch_ready), 32'd1, "dispatch ready when drained");
      check_value(32'(issue_valid), 32'd0, "issue valid when drained");
      check_value(32'(woke_at_write > 0), 32'd1, "sources woken at write");
      check_value(32'(woke_later > 0), 32'd1, "sources woken after write");
      $display("issued %0d micro-ops in %0d cycles, %0d woken at write, %0d woken later",
               issued, cycles, woke_at_write, woke_later);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire
